//--- hw/fetch_config.svh
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// First PC fetched after reset
`define FETCH_RESET_ADDR        32'h0000_0100

`define FETCH_BUF_DEPTH         4
`define FETCH_MAX_OUTSTANDING   2   // Also the tag queue depth
`define FETCH_TIMEOUT           16  // Cycles without ack

`endif

//--- hw/fetch_pkg.sv
package fetch_pkg;

    typedef logic [31:0] fetch_addr_t;

    typedef logic [31:0] fetch_instr_t;

    // PC travels with its instruction through the prefetch queue
    typedef struct packed
    {
        fetch_addr_t  pc;
        fetch_instr_t instr;
    } fetch_entry_t;

    typedef enum logic [1:0]
    {
        RUN     = 2'b00,
        DISCARD = 2'b01,    // Dropping answers that predate a redirect
        FAULT   = 2'b10     // Bus timed out, waiting for a redirect
    } fetch_state_t;

endpackage

//--- hw/fetch_queue_if.sv
`timescale 1ns/1ps

interface fetch_queue_if
#(
    parameter type T     = logic,
    parameter int  DEPTH = 4
);

    localparam int CW = $clog2(DEPTH + 1);

    logic          push;
    T              push_data;
    logic          pop;
    T              pop_data;
    logic          empty;
    logic          full;
    logic [CW-1:0] count;
    logic          clear;   // Wins over push

    modport writer (output push, output push_data, output clear);

    modport reader (output pop, input pop_data, input empty);

    modport store
    (
        input  push, push_data, pop, clear,
        output pop_data, empty, full, count
    );

endinterface

//--- hw/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue
#(
    parameter type T     = logic,
    parameter int  DEPTH = 4
)
(
    input  logic         i_clk,
    input  logic         i_rst_n,
    fetch_queue_if.store q
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_push;
    logic          do_pop;

    // Wrap explicitly so a depth that is not a power of two still works
    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
        logic [AW-1:0] nxt;
        nxt = (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
        return nxt;
    endfunction

    assign do_push = q.push && !q.clear;
    assign do_pop  = q.pop && !q.clear;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else if (q.clear)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= ptr_inc(wr_ptr);
            if (do_pop)
                rd_ptr <= ptr_inc(rd_ptr);
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (do_push)
            mem[wr_ptr] <= q.push_data;
    end

    assign q.pop_data = mem[rd_ptr];  // Head, no read latency
    assign q.empty    = (count == '0);
    assign q.full     = (count == CW'(DEPTH));
    assign q.count    = count;

    a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(q.push && q.full && !q.clear));

    a_no_underflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(q.pop && q.empty));

endmodule

//--- hw/fetch_timeout_counter.sv
`timescale 1ns/1ps

module fetch_timeout_counter
#(
    parameter int LIMIT = 16
)
(
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_active,
    input  logic i_ack,
    input  logic i_restart,
    output logic o_expired
);

    localparam int CW = $clog2(LIMIT + 1);

    logic [CW-1:0] count;
    logic          idle_cycle;

    // Request pending and nothing came back
    assign idle_cycle = i_active && !i_ack;

    // Fires on the LIMIT-th idle cycle itself
    assign o_expired = idle_cycle && (count == CW'(LIMIT - 1));

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            count <= '0;
        else if (i_restart || !idle_cycle || o_expired)
            count <= '0;
        else
            count <= count + 1'b1;
    end

    a_count_bound: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        count < CW'(LIMIT));

endmodule

//--- hw/fetch_ctrl_fsm.sv
`timescale 1ns/1ps

`include "fetch_config.svh"

module fetch_ctrl_fsm
    import fetch_pkg::*;
#(
    localparam int ICW = $clog2(`FETCH_BUF_DEPTH + 1),
    localparam int TCW = $clog2(`FETCH_MAX_OUTSTANDING + 1)
)
(
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_pc_select,
    input  fetch_addr_t         i_pc_target,
    input  logic                i_ack,
    input  logic                i_timeout,
    input  logic [ICW-1:0]      i_instr_count,
    fetch_queue_if.writer       tag_wr,
    input  logic [TCW-1:0]      tag_cnt,
    output logic                o_cyc,
    output fetch_addr_t         o_addr,
    output logic                o_discard,
    output logic                o_fault,
    output logic                o_instr_clear
);

    localparam int SW = ICW + TCW;

    fetch_state_t   state;
    fetch_addr_t    pc;
    logic [TCW-1:0] discard_cnt;
    logic [TCW-1:0] discard_next;
    logic [SW-1:0]  occupancy;
    logic           has_credit;
    logic           started;

    // Every request holds either a tag slot or an instruction slot
    assign occupancy  = SW'(i_instr_count) + SW'(tag_cnt);
    assign has_credit = (occupancy < SW'(`FETCH_BUF_DEPTH)) &&
                        (tag_cnt < TCW'(`FETCH_MAX_OUTSTANDING));

    // All tags still queued at a redirect belong to the old stream
    assign discard_next = tag_cnt - TCW'(i_ack);

    // No issue on the redirect cycle, so the old PC never leaks out
    assign o_cyc = started && (state != FAULT) && has_credit &&
                   !i_timeout && !i_pc_select;
    assign o_addr = pc;

    assign tag_wr.push      = o_cyc;
    assign tag_wr.push_data = pc;
    assign tag_wr.clear     = 1'b0;  // Tags must outlive a redirect

    assign o_discard     = (state != RUN);
    assign o_fault       = (state == FAULT);
    assign o_instr_clear = i_pc_select;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            started <= 1'b0;
        else
            started <= 1'b1;
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            pc <= `FETCH_RESET_ADDR;
        else if (i_pc_select)
            pc <= i_pc_target;
        else if (o_cyc)
            pc <= pc + 32'd4;
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            state       <= RUN;
            discard_cnt <= '0;
        end
        else if (i_pc_select)
        begin
            discard_cnt <= discard_next;
            state       <= (discard_next == '0) ? RUN : DISCARD;
        end
        else
        begin
            case (state)
                RUN:
                begin
                    if (i_timeout)
                        state <= FAULT;
                end
                DISCARD:
                begin
                    if (i_timeout)
                        state <= FAULT;
                    else if (i_ack)
                    begin
                        discard_cnt <= discard_cnt - 1'b1;
                        if (discard_cnt == TCW'(1))
                            state <= RUN;
                    end
                end
                FAULT:
                begin
                    // Held until the next redirect
                end
                default:
                    state <= FAULT;
            endcase
        end
    end

    a_target_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_pc_select |-> (i_pc_target[1:0] == 2'b00));

    // A timeout stops issue until the next redirect
    a_no_cyc_in_fault: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_timeout || (state == FAULT)) && !i_pc_select |=> !o_cyc);

endmodule

//--- hw/fetch_top.sv
`timescale 1ns/1ps

`include "fetch_config.svh"

module fetch_top
    import fetch_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  logic         i_stall,
    input  logic         i_pc_select,
    input  fetch_addr_t  i_pc_target,
    input  fetch_instr_t i_instruction,
    input  logic         i_ack,
    output fetch_addr_t  o_addr,
    output logic         o_cyc,
    output fetch_addr_t  o_pc,
    output fetch_instr_t o_instruction,
    output logic         o_ready,
    output logic         o_fault
);

    logic discard;
    logic instr_clear;
    logic timeout;

    // PC tags of requests on the bus, oldest first
    fetch_queue_if #(
        .T     (fetch_addr_t),
        .DEPTH (`FETCH_MAX_OUTSTANDING)
    ) tag_q ();

    fetch_queue_if #(
        .T     (fetch_entry_t),
        .DEPTH (`FETCH_BUF_DEPTH)
    ) instr_q ();

    fetch_queue #(
        .T     (fetch_addr_t),
        .DEPTH (`FETCH_MAX_OUTSTANDING)
    ) u_tag_q (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .q       (tag_q)
    );

    fetch_queue #(
        .T     (fetch_entry_t),
        .DEPTH (`FETCH_BUF_DEPTH)
    ) u_instr_q (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .q       (instr_q)
    );

    fetch_ctrl_fsm u_ctrl (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_pc_select   (i_pc_select),
        .i_pc_target   (i_pc_target),
        .i_ack         (i_ack),
        .i_timeout     (timeout),
        .i_instr_count (instr_q.count),
        .tag_wr        (tag_q),
        .tag_cnt       (tag_q.count),
        .o_cyc         (o_cyc),
        .o_addr        (o_addr),
        .o_discard     (discard),
        .o_fault       (o_fault),
        .o_instr_clear (instr_clear)
    );

    fetch_timeout_counter #(
        .LIMIT (`FETCH_TIMEOUT)
    ) u_timeout (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_active  (!tag_q.empty),
        .i_ack     (i_ack),
        .i_restart (i_pc_select),
        .o_expired (timeout)
    );

    // Answers come in issue order, so the head tag is this ack's PC
    assign tag_q.pop = i_ack;

    assign instr_q.push      = i_ack && !discard;
    assign instr_q.push_data = '{pc: tag_q.pop_data, instr: i_instruction};
    assign instr_q.clear     = instr_clear;

    assign o_ready       = !instr_q.empty && !i_stall;
    assign instr_q.pop   = o_ready;
    assign o_pc          = instr_q.pop_data.pc;
    assign o_instruction = instr_q.pop_data.instr;

    // Credit keeps tags plus buffered entries within the buffer size
    a_credit_bound: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (int'(tag_q.count) + int'(instr_q.count)) <= `FETCH_BUF_DEPTH);

endmodule

//--- sim/fetch_tb.sv
`timescale 1ns/1ps

`include "fetch_config.svh"

module fetch_tb
    import fetch_pkg::*;
;

    localparam int          CYCLE_LIMIT = 2000;
    localparam fetch_instr_t DATA_MASK  = 32'hA5A5_0000;

    logic         i_clk;
    logic         i_rst_n;
    logic         i_stall;
    logic         i_pc_select;
    fetch_addr_t  i_pc_target;
    fetch_instr_t i_instruction;
    logic         i_ack;
    fetch_addr_t  o_addr;
    logic         o_cyc;
    fetch_addr_t  o_pc;
    fetch_instr_t o_instruction;
    logic         o_ready;
    logic         o_fault;

    integer seed = 50783;
    int     cycle = 0;
    int     errors = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    logic   hold = 1'b0;

    fetch_addr_t  req_addr[$];
    int           req_due[$];
    int           last_due = 0;
    fetch_addr_t  got_pc[$];
    fetch_instr_t got_instr[$];
    fetch_addr_t  next_pc;

    fetch_top u_fetch_top (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_stall       (i_stall),
        .i_pc_select   (i_pc_select),
        .i_pc_target   (i_pc_target),
        .i_instruction (i_instruction),
        .i_ack         (i_ack),
        .o_addr        (o_addr),
        .o_cyc         (o_cyc),
        .o_pc          (o_pc),
        .o_instruction (o_instruction),
        .o_ready       (o_ready),
        .o_fault       (o_fault)
    );

    always #4 i_clk = ~i_clk;

    // Memory model answering in order after 1 to 3 cycles
    always @(posedge i_clk)
    begin
        int due;
        cycle = cycle + 1;
        if (i_rst_n && o_cyc)
        begin
            due = cycle + ({$random(seed)} % 3);
            if (due <= last_due)
                due = last_due + 1;
            last_due = due;
            req_addr.push_back(o_addr);
            req_due.push_back(due);
        end
        #1;
        i_ack = 1'b0;
        if (!hold && req_addr.size() > 0 && req_due[0] <= cycle)
        begin
            i_ack         = 1'b1;
            i_instruction = req_addr[0] ^ DATA_MASK;
            void'(req_addr.pop_front());
            void'(req_due.pop_front());
        end
    end

    // Decode side monitor that drops everything before a redirect
    always @(posedge i_clk)
    begin
        if (i_rst_n)
        begin
            if (o_ready && i_stall)
            begin
                $display("Mismatch at %0t: o_ready high while stalled", $time);
                errors = errors + 1;
            end
            if (i_pc_select)
            begin
                got_pc.delete();
                got_instr.delete();
            end
            else if (o_ready)
            begin
                got_pc.push_back(o_pc);
                got_instr.push_back(o_instruction);
            end
        end
    end

    always @(posedge i_clk)
    begin
        if (cycle > CYCLE_LIMIT)
        begin
            $display("Run aborted: cycle limit of %0d reached before the tests finished",
                     CYCLE_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic check_pc(input fetch_addr_t got, input fetch_addr_t exp, input string what);
        if (got !== exp)
        begin
            $display("Mismatch at %0t: %s pc got %h expected %h", $time, what, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic check_instr(input fetch_instr_t got, input fetch_instr_t exp,
                               input string what);
        if (got !== exp)
        begin
            $display("Mismatch at %0t: %s instr got %h expected %h", $time, what, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic next_cycle();
        @(posedge i_clk);
        #1;
    endtask

    task automatic take_entry(output fetch_addr_t pc, output fetch_instr_t instr);
        while (got_pc.size() == 0)
            next_cycle();
        pc    = got_pc.pop_front();
        instr = got_instr.pop_front();
    endtask

    // Expects n consecutive entries from start
    task automatic expect_stream(input fetch_addr_t start, input int n, input string what);
        fetch_addr_t  pc;
        fetch_instr_t instr;
        for (int k = 0; k < n; k++)
        begin
            take_entry(pc, instr);
            check_pc(pc, start + 32'(4 * k), what);
            check_instr(instr, (start + 32'(4 * k)) ^ DATA_MASK, what);
        end
        next_pc = start + 32'(4 * n);
    endtask

    task automatic redirect(input fetch_addr_t target);
        i_pc_select = 1'b1;
        i_pc_target = target;
        next_cycle();
        i_pc_select = 1'b0;
    endtask

    task automatic report(input string name, input int errors_before);
        tests_run = tests_run + 1;
        if (errors == errors_before)
            $display("[%0t] %s: ok", $time, name);
        else
        begin
            tests_failed = tests_failed + 1;
            $display("[%0t] %s: %0d errors", $time, name, errors - errors_before);
        end
    endtask

    task automatic test_sequential();
        int e0;
        e0 = errors;
        expect_stream(`FETCH_RESET_ADDR, 21, "sequential");
        report("sequential fetch", e0);
    endtask

    task automatic test_backpressure();
        int           e0;
        int           taken;
        int           len;
        fetch_addr_t  pc;
        fetch_instr_t instr;
        e0    = errors;
        taken = 0;
        while (taken < 30)
        begin
            len     = 1 + {$random(seed)} % 12;
            i_stall = 1'b1;
            repeat (len) next_cycle();
            if (len >= 10)
            begin
                @(negedge i_clk);
                check_flag(o_cyc, 1'b0, "o_cyc with credit used up");
                next_cycle();
            end
            i_stall = 1'b0;
            repeat (1 + {$random(seed)} % 4) next_cycle();
            while (got_pc.size() > 0 && taken < 30)
            begin
                take_entry(pc, instr);
                check_pc(pc, next_pc, "backpressure");
                check_instr(instr, next_pc ^ DATA_MASK, "backpressure");
                next_pc = next_pc + 32'd4;
                taken   = taken + 1;
            end
        end
        report("back-pressure", e0);
    endtask

    task automatic test_redirect();
        int e0;
        e0 = errors;
        repeat (3) next_cycle();
        redirect(32'h0000_2000);
        expect_stream(32'h0000_2000, 10, "redirect");
        report("redirect mid-stream", e0);
    endtask

    task automatic test_double_redirect();
        int e0;
        e0 = errors;
        repeat (2) next_cycle();
        redirect(32'h0000_3000);
        repeat ({$random(seed)} % 2) next_cycle();
        redirect(32'h0000_4000);
        expect_stream(32'h0000_4000, 10, "double redirect");
        report("back-to-back redirects", e0);
    endtask

    task automatic test_timeout();
        int e0;
        int waited;
        e0     = errors;
        hold   = 1'b1;
        waited = 0;
        while (!o_fault && waited < 50)
        begin
            next_cycle();
            waited = waited + 1;
        end
        if (!o_fault)
        begin
            $display("Timeout test: o_fault never rose while the bus was silent");
            errors = errors + 1;
        end
        got_pc.delete();
        got_instr.delete();
        hold = 1'b0;    // Late answers land while faulted
        repeat (10)
        begin
            @(negedge i_clk);
            check_flag(o_cyc, 1'b0, "o_cyc in fault");
            check_flag(o_fault, 1'b1, "o_fault held");
            next_cycle();
        end
        check_flag(got_pc.size() == 0, 1'b1, "no delivery in fault");
        redirect(32'h0000_5000);
        @(negedge i_clk);
        check_flag(o_fault, 1'b0, "o_fault after redirect");
        expect_stream(32'h0000_5000, 10, "after fault");
        report("timeout and recovery", e0);
    endtask

    initial
    begin
        i_clk         = 1'b0;
        i_rst_n       = 1'b0;
        i_stall       = 1'b0;
        i_pc_select   = 1'b0;
        i_pc_target   = '0;
        i_instruction = '0;
        i_ack         = 1'b0;
        repeat (2) @(posedge i_clk);
        #1;
        check_flag(o_cyc, 1'b0, "o_cyc in reset");
        check_flag(o_ready, 1'b0, "o_ready in reset");
        check_flag(o_fault, 1'b0, "o_fault in reset");
        i_rst_n = 1'b1;

        test_sequential();
        test_backpressure();
        test_redirect();
        test_double_redirect();
        test_timeout();

        $display("Tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

//--- files.f
+incdir+hw
hw/fetch_pkg.sv
hw/fetch_queue_if.sv
hw/fetch_queue.sv
hw/fetch_timeout_counter.sv
hw/fetch_ctrl_fsm.sv
hw/fetch_top.sv
sim/fetch_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the fetch stage testbench with Verilator

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f files.f --top-module fetch_tb -o fetch_sim \
    > build.log 2>&1 &&
./obj_dir/fetch_sim > sim.log 2>&1 ||
{ echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }

cat sim.log

grep -q "All tests passed!" sim.log && echo "PASS" ||
{ echo "FAIL"; exit 1; }
